// File: build.f
src/rv_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/hazard_unit.sv
src/mem_wb_stage.sv
src/rv_core.sv
sim/core_chk.sv
sim/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_core.sv
// RV32I core testbench
`timescale 1ns/10ps

module tb_core;

    localparam int          CLK_PERIOD      = 40;
    localparam int          PROG_LEN        = 27;
    localparam int          N_STORES        = 9;
    localparam int          DM_WORDS        = 64;
    localparam int          WATCHDOG_CYCLES = PROG_LEN * 4 + 60;
    localparam int          QUIET_CYCLES    = 40;
    localparam logic [31:0] SEED            = 32'h42aa;

    // RV32I major opcodes used with the I-type format
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LD  = 7'b0000011;

    localparam logic [11:0] IMM_A  = 12'd100;
    localparam logic [11:0] IMM_B  = 12'hfdb;   // -37
    localparam logic [11:0] IMM_LU = 12'd77;
    localparam logic [11:0] IMM_BR = 12'd5;
    localparam logic [11:0] LD_OFF = 12'h080;

    // Store data is a plain value, or the loaded shadow word plus an offset
    localparam logic RULE_VALUE = 1'b0;
    localparam logic RULE_LOAD  = 1'b1;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dm_addr;
    logic        dm_we;
    logic [31:0] dm_wdata;
    logic [31:0] dm_rdata;

    logic [31:0] prog     [0:63];
    logic [31:0] dmem     [0:DM_WORDS-1];
    logic [31:0] shadow   [0:DM_WORDS-1];
    logic [31:0] exp_addr [0:15];
    logic        exp_rule [0:15];
    logic [31:0] exp_arg  [0:15];
    logic [5:0]  pc_idx;
    logic [3:0]  n_exp;
    int          store_count = 0;
    int          err_count   = 0;

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    rv_core dut_i (
        .clk(clk), .rst(rst),
        .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
        .dm_addr_o(dm_addr), .dm_we_o(dm_we), .dm_wdata_o(dm_wdata), .dm_rdata_i(dm_rdata)
    );

    //////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////
    assign imem_rdata = prog[imem_addr[7:2]];
    assign dm_rdata   = dmem[dm_addr[7:2]];

    // Store commits at the rising edge
    always @(posedge clk) begin
        if (dm_we === 1'b1) begin
            dmem[dm_addr[7:2]] = dm_wdata;
        end
    end

    //////////////////////////////////////////////////
    // Encoders and tables
    //////////////////////////////////////////////////
    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic put_instr(input logic [31:0] word);
        prog[pc_idx] = word;
        pc_idx = pc_idx + 6'd1;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic rule,
                                input logic [31:0] arg);
        exp_addr[n_exp] = addr;
        exp_rule[n_exp] = rule;
        exp_arg[n_exp]  = arg;
        n_exp = n_exp + 4'd1;
    endtask

    function automatic logic [31:0] store_value(input logic [3:0] k);
        if (exp_rule[k] == RULE_LOAD) begin
            return shadow[LD_OFF[7:2]] + exp_arg[k];
        end
        return exp_arg[k];
    endfunction

    task automatic build_program();
        pc_idx = 6'd0;
        // Dependent ALU chain
        put_instr(itype(OP_IMM, 3'b000, 5'd1, 5'd0, IMM_A));
        put_instr(itype(OP_IMM, 3'b000, 5'd2, 5'd0, IMM_B));
        put_instr(rtype(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
        put_instr(rtype(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1));
        put_instr(rtype(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd1));
        put_instr(rtype(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd2));
        put_instr(rtype(7'b0000000, 3'b100, 5'd7, 5'd6, 5'd3));
        put_instr(rtype(7'b0000000, 3'b010, 5'd8, 5'd4, 5'd3));
        put_instr(stype(5'd3, 5'd0, 12'd0));
        put_instr(stype(5'd4, 5'd0, 12'd4));
        put_instr(stype(5'd5, 5'd0, 12'd8));
        put_instr(stype(5'd6, 5'd0, 12'd12));
        put_instr(stype(5'd7, 5'd0, 12'd16));
        put_instr(stype(5'd8, 5'd0, 12'd20));
        // Load-use pair
        put_instr(itype(OP_LD, 3'b010, 5'd9, 5'd0, LD_OFF));
        put_instr(itype(OP_IMM, 3'b000, 5'd10, 5'd9, IMM_LU));
        put_instr(stype(5'd10, 5'd0, 12'd24));
        // Two taken branches, then two that fall through
        put_instr(itype(OP_IMM, 3'b000, 5'd11, 5'd0, IMM_BR));
        put_instr(btype(3'b000, 5'd11, 5'd11, 13'd8));
        put_instr(stype(5'd1, 5'd0, 12'd28));
        put_instr(btype(3'b001, 5'd11, 5'd0, 13'd8));
        put_instr(stype(5'd1, 5'd0, 12'd32));
        put_instr(btype(3'b000, 5'd11, 5'd0, 13'd8));
        put_instr(stype(5'd11, 5'd0, 12'd36));
        put_instr(btype(3'b001, 5'd11, 5'd11, 13'd8));
        put_instr(stype(5'd2, 5'd0, 12'd40));
        // Spin on beq x0, x0, 0
        put_instr(btype(3'b000, 5'd0, 5'd0, 13'd0));
    endtask

    task automatic build_expectations();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] v5;
        logic [31:0] v6;
        logic [31:0] v7;
        logic [31:0] v8;
        v1 = sext12(IMM_A);
        v2 = sext12(IMM_B);
        v3 = v1 + v2;
        v4 = v3 - v1;
        v5 = v4 & v1;
        v6 = v5 | v2;
        v7 = v6 ^ v3;
        v8 = ($signed(v4) < $signed(v3)) ? 32'd1 : 32'd0;
        n_exp = 4'd0;
        expect_store(32'd0,  RULE_VALUE, v3);
        expect_store(32'd4,  RULE_VALUE, v4);
        expect_store(32'd8,  RULE_VALUE, v5);
        expect_store(32'd12, RULE_VALUE, v6);
        expect_store(32'd16, RULE_VALUE, v7);
        expect_store(32'd20, RULE_VALUE, v8);
        expect_store(32'd24, RULE_LOAD,  sext12(IMM_LU));
        expect_store(32'd36, RULE_VALUE, sext12(IMM_BR));
        expect_store(32'd40, RULE_VALUE, v2);
    endtask

    //////////////////////////////////////////////////
    // Store monitor walks the table in order
    //////////////////////////////////////////////////
    initial begin
        logic [31:0] want;
        forever begin
            @(posedge clk);
            if (!rst && dm_we !== 1'b0) begin
                if (dm_we !== 1'b1) begin
                    err_count++;
                    $display("dm_we_o is unknown at t=%0t", $time);
                end else if (store_count >= N_STORES) begin
                    err_count++;
                    store_count++;
                    $display("Unexpected extra store at t=%0t to address %h", $time, dm_addr);
                end else begin
                    want = store_value(store_count[3:0]);
                    if (dm_addr !== exp_addr[store_count[3:0]]) begin
                        err_count++;
                        $display("[FAIL] t=%0t dm_addr_o expected %h got %h",
                                 $time, exp_addr[store_count[3:0]], dm_addr);
                    end
                    if (dm_wdata !== want) begin
                        err_count++;
                        $display("[FAIL] t=%0t dm_wdata_o expected %h got %h",
                                 $time, want, dm_wdata);
                    end
                    store_count++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d of %0d stores seen",
                 WATCHDOG_CYCLES, store_count, N_STORES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] word;
        int          asrt_fails;
        void'($urandom(SEED));
        for (int i = 0; i < DM_WORDS; i++) begin
            word = $urandom();
            dmem[i[5:0]]   = word;
            shadow[i[5:0]] = word;
        end
        for (int i = 0; i < 64; i++) begin
            prog[i[5:0]] = 32'h0;
        end
        build_program();
        build_expectations();

        // Reset for three rising edges
        repeat (3) begin
            @(negedge clk);
            if (dm_we !== 1'b0) begin
                err_count++;
                $display("[FAIL] t=%0t dm_we_o expected 0 got %b", $time, dm_we);
            end
        end
        rst = 1'b0;

        @(posedge clk);
        if (imem_addr !== 32'd0) begin
            err_count++;
            $display("[FAIL] t=%0t imem_addr_o expected %h got %h", $time, 32'd0, imem_addr);
        end

        while (store_count < N_STORES) begin
            @(posedge clk);
        end
        // Core parks on its final branch and stores nothing more
        repeat (QUIET_CYCLES) @(posedge clk);
        if (store_count != N_STORES) begin
            err_count++;
            $display("Saw %0d stores where %0d were expected", store_count, N_STORES);
        end

        asrt_fails = dut_i.chk_i.fail_cnt;
        $display("Summary: %0d stores, %0d check errors, %0d assertion failures",
                 store_count, err_count, asrt_fails);
        if (err_count == 0 && asrt_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/core_chk.sv
// Core protocol assertions
`timescale 1ns/10ps

module core_chk (
    input logic        clk,
    input logic        rst,
    input logic        dm_we_i,
    input logic [31:0] dm_addr_i,
    input logic [31:0] imem_addr_i,
    input logic        stall_i
);

    int fail_cnt = 0;

    we_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(dm_we_i))
        else begin
            $error("dm_we_o is unknown");
            fail_cnt++;
        end

    store_aligned: assert property (@(posedge clk) disable iff (rst)
        dm_we_i |-> (dm_addr_i[1:0] == 2'b00))
        else begin
            $error("store address %h is not word aligned", dm_addr_i);
            fail_cnt++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr_i[1:0] == 2'b00)
        else begin
            $error("fetch address %h is not word aligned", imem_addr_i);
            fail_cnt++;
        end

    // Load-use hold lasts a single cycle
    stall_once: assert property (@(posedge clk) disable iff (rst) stall_i |=> !stall_i)
        else begin
            $error("stall held for two cycles in a row");
            fail_cnt++;
        end

endmodule

bind rv_core core_chk chk_i (
    .clk(clk), .rst(rst),
    .dm_we_i(dm_we_o), .dm_addr_i(dm_addr_o),
    .imem_addr_i(imem_addr_o), .stall_i(stall)
);

// File: src/rv_core.sv
// Five-stage RV32I core top
`timescale 1ns/10ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] imem_rdata_i,
    output logic [rv_pkg::XLEN-1:0] dm_addr_o,
    output logic                    dm_we_o,
    output logic [rv_pkg::XLEN-1:0] dm_wdata_o,
    input  logic [rv_pkg::XLEN-1:0] dm_rdata_i
);

    rv_pkg::if_id_t                if_id;
    rv_pkg::id_ex_t                id_ex;
    rv_pkg::ex_mem_t               ex_mem;
    rv_pkg::mem_wb_t               mem_wb;
    rv_pkg::fwd_sel_t              fwd_a;
    rv_pkg::fwd_sel_t              fwd_b;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1_idx;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2_idx;
    logic [rv_pkg::XLEN-1:0]       branch_target;
    logic                          branch_taken;
    logic                          stall;
    logic                          bubble;

    // Decode squash on load-use or taken branch
    assign bubble = stall | branch_taken;

    fetch_stage u_fetch (
        .clk(clk), .rst(rst),
        .stall_i(stall), .redirect_i(branch_taken), .redirect_pc_i(branch_target),
        .imem_rdata_i(imem_rdata_i), .imem_addr_o(imem_addr_o), .if_id_o(if_id)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst),
        .if_id_i(if_id), .bubble_i(bubble), .wb_i(mem_wb),
        .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx), .id_ex_o(id_ex)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst),
        .id_ex_i(id_ex), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .wb_value_i(mem_wb.value),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target), .ex_mem_o(ex_mem)
    );

    hazard_unit u_hazard (
        .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
        .id_ex_i(id_ex), .ex_mem_i(ex_mem), .mem_wb_i(mem_wb),
        .stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .rst(rst),
        .ex_mem_i(ex_mem), .dm_rdata_i(dm_rdata_i),
        .dm_addr_o(dm_addr_o), .dm_we_o(dm_we_o), .dm_wdata_o(dm_wdata_o),
        .mem_wb_o(mem_wb)
    );

endmodule

// File: src/mem_wb_stage.sv
// Memory access and writeback register
`timescale 1ns/10ps

module mem_wb_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::ex_mem_t         ex_mem_i,
    input  logic [rv_pkg::XLEN-1:0] dm_rdata_i,
    output logic [rv_pkg::XLEN-1:0] dm_addr_o,
    output logic                    dm_we_o,
    output logic [rv_pkg::XLEN-1:0] dm_wdata_o,
    output rv_pkg::mem_wb_t         mem_wb_o
);

    rv_pkg::mem_wb_t mem_wb_q;

    // Data port straight from EX/MEM
    assign dm_addr_o  = ex_mem_i.alu_result;
    assign dm_we_o    = ex_mem_i.mem_write;
    assign dm_wdata_o = ex_mem_i.store_data;
    assign mem_wb_o   = mem_wb_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_q <= '0;
        end else begin
            // Loaded word or ALU result
            mem_wb_q.value     <= ex_mem_i.mem_read ? dm_rdata_i : ex_mem_i.alu_result;
            mem_wb_q.rd        <= ex_mem_i.rd;
            mem_wb_q.reg_write <= ex_mem_i.reg_write;
        end
    end

endmodule

// File: src/hazard_unit.sv
// Load-use stall and forwarding control
`timescale 1ns/10ps

module hazard_unit (
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_idx_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_idx_i,
    input  rv_pkg::id_ex_t                id_ex_i,
    input  rv_pkg::ex_mem_t               ex_mem_i,
    input  rv_pkg::mem_wb_t               mem_wb_i,
    output logic                          stall_o,
    output rv_pkg::fwd_sel_t              fwd_a_o,
    output rv_pkg::fwd_sel_t              fwd_b_o
);

    // Youngest writer of src wins
    function automatic rv_pkg::fwd_sel_t pick_src(
        input logic [rv_pkg::REG_ADDR_W-1:0] src,
        input rv_pkg::ex_mem_t               exm,
        input rv_pkg::mem_wb_t               mwb
    );
        if (src != '0 && exm.reg_write && exm.rd == src) begin
            return rv_pkg::FWD_EXMEM;
        end else if (src != '0 && mwb.reg_write && mwb.rd == src) begin
            return rv_pkg::FWD_MEMWB;
        end
        return rv_pkg::FWD_NONE;
    endfunction

    assign fwd_a_o = pick_src(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign fwd_b_o = pick_src(id_ex_i.rs2, ex_mem_i, mem_wb_i);

    // Load in EX feeding the instruction in decode
    assign stall_o = id_ex_i.mem_read && id_ex_i.rd != '0
                  && (id_ex_i.rd == rs1_idx_i || id_ex_i.rd == rs2_idx_i);

endmodule

// File: src/execute_stage.sv
// Execute stage with ALU and branch resolve
`timescale 1ns/10ps

module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::id_ex_t          id_ex_i,
    input  rv_pkg::fwd_sel_t        fwd_a_i,
    input  rv_pkg::fwd_sel_t        fwd_b_i,
    input  logic [rv_pkg::XLEN-1:0] wb_value_i,
    output logic                    branch_taken_o,
    output logic [rv_pkg::XLEN-1:0] branch_target_o,
    output rv_pkg::ex_mem_t         ex_mem_o
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    rv_pkg::ex_mem_t         ex_mem_q;

    //////////////////////////////////////////////////
    // Operand forwarding
    //////////////////////////////////////////////////
    always_comb begin
        case (fwd_a_i)
            rv_pkg::FWD_EXMEM: op_a = ex_mem_q.alu_result;
            rv_pkg::FWD_MEMWB: op_a = wb_value_i;
            default:           op_a = id_ex_i.rs1_val;
        endcase
        case (fwd_b_i)
            rv_pkg::FWD_EXMEM: op_b = ex_mem_q.alu_result;
            rv_pkg::FWD_MEMWB: op_b = wb_value_i;
            default:           op_b = id_ex_i.rs2_val;
        endcase
    end

    assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::ALU_SUB: alu_res = op_a - alu_b;
            rv_pkg::ALU_AND: alu_res = op_a & alu_b;
            rv_pkg::ALU_OR:  alu_res = op_a | alu_b;
            rv_pkg::ALU_XOR: alu_res = op_a ^ alu_b;
            rv_pkg::ALU_SLT: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default:         alu_res = op_a + alu_b;
        endcase
    end

    // BEQ on equal, BNE on not equal
    assign branch_taken_o  = id_ex_i.is_branch & ((op_a == op_b) ^ id_ex_i.branch_ne);
    assign branch_target_o = id_ex_i.pc + id_ex_i.imm;
    assign ex_mem_o        = ex_mem_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.alu_result <= alu_res;
            ex_mem_q.store_data <= op_b;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.mem_read   <= id_ex_i.mem_read;
            ex_mem_q.mem_write  <= id_ex_i.mem_write;
            ex_mem_q.reg_write  <= id_ex_i.reg_write;
        end
    end

endmodule

// File: src/decode_stage.sv
// Decode and register file
`timescale 1ns/10ps

module decode_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  rv_pkg::if_id_t                if_id_i,
    input  logic                          bubble_i,
    input  rv_pkg::mem_wb_t               wb_i,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_idx_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_idx_o,
    output rv_pkg::id_ex_t                id_ex_o
);

    logic [rv_pkg::XLEN-1:0]       regs [0:31];
    logic [rv_pkg::XLEN-1:0]       instr;
    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic                          valid;
    logic                          uses_rs2;
    rv_pkg::id_ex_t                dec;
    rv_pkg::id_ex_t                id_ex_q;

    assign instr  = if_id_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    //////////////////////////////////////////////////
    // Control and immediate decode
    //////////////////////////////////////////////////
    always_comb begin
        dec      = '0;
        valid    = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                valid         = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000);
                uses_rs2      = 1'b1;
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b111:  dec.alu_op = rv_pkg::ALU_AND;
                    3'b110:  dec.alu_op = rv_pkg::ALU_OR;
                    3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
                    3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
                    default: valid = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD: begin
                // ADDI and LW share the I-type adder path
                valid         = (opcode == rv_pkg::OPC_OP_IMM) ? (funct3 == 3'b000)
                                                               : (funct3 == 3'b010);
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.mem_read  = (opcode == rv_pkg::OPC_LOAD);
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
            end
            rv_pkg::OPC_STORE: begin
                valid         = (funct3 == 3'b010);
                uses_rs2      = 1'b1;
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
                dec.imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_pkg::OPC_BRANCH: begin
                valid         = (funct3 == 3'b000) || (funct3 == 3'b001);
                uses_rs2      = 1'b1;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                dec.imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
            end
            default: valid = 1'b0;
        endcase

        dec.pc      = if_id_i.pc;
        dec.rd      = instr[11:7];
        dec.rs1     = valid ? rs1 : '0;
        dec.rs2     = (valid && uses_rs2) ? rs2 : '0;
        dec.rs1_val = (dec.rs1 == '0) ? '0
                    : (wb_i.reg_write && wb_i.rd == dec.rs1) ? wb_i.value : regs[dec.rs1];
        dec.rs2_val = (dec.rs2 == '0) ? '0
                    : (wb_i.reg_write && wb_i.rd == dec.rs2) ? wb_i.value : regs[dec.rs2];

        // Unsupported encodings travel as bubbles
        if (!valid) begin
            dec = '0;
        end
    end

    assign rs1_idx_o = dec.rs1;
    assign rs2_idx_o = dec.rs2;
    assign id_ex_o   = id_ex_q;

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wb_i.reg_write && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex_q <= '0;
        end else if (bubble_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= dec;
        end
    end

endmodule

// File: src/fetch_stage.sv
// Instruction fetch stage
`timescale 1ns/10ps

module fetch_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall_i,
    input  logic                     redirect_i,
    input  logic [rv_pkg::XLEN-1:0]  redirect_pc_i,
    input  logic [rv_pkg::XLEN-1:0]  imem_rdata_i,
    output logic [rv_pkg::XLEN-1:0]  imem_addr_o,
    output rv_pkg::if_id_t           if_id_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;
    rv_pkg::if_id_t          if_id_q;

    assign imem_addr_o = pc_q;
    assign if_id_o     = if_id_q;

    // Redirect wins over a load-use hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q    <= '0;
            if_id_q <= '0;
        end else if (redirect_i) begin
            pc_q          <= redirect_pc_i;
            // All-zero word decodes as a bubble
            if_id_q.pc    <= '0;
            if_id_q.instr <= '0;
        end else if (!stall_i) begin
            pc_q          <= pc_q + 32'd4;
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= imem_rdata_i;
        end
    end

endmodule

// File: src/rv_pkg.sv
// RV32I core shared definitions
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_t;

    //////////////////////////////////////////////////
    // Pipeline boundaries
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        logic                  is_branch;
        logic                  branch_ne;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       value;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
    } mem_wb_t;

endpackage
